// File: src/mipsConsts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// Word and field widths
`define DATA_WIDTH      32
`define REG_ADDR_WIDTH  5
`define IMM_WIDTH       16
`define TARGET_WIDTH    26
`define SHAMT_WIDTH     5
`define OPCODE_WIDTH    6
`define FUNCT_WIDTH     6

// First fetch address
`define RESET_PC        32'h0000_0000

// Low bit of each instruction field
`define OP_LSB          26
`define RS_LSB          21
`define RT_LSB          16
`define RD_LSB          11
`define SHAMT_LSB       6
`define FUNCT_LSB       0

`endif

// File: src/mipsPkg.sv
`include "mipsConsts.svh"

package mipsPkg;

   typedef logic [`DATA_WIDTH-1:0] wordT;
   typedef logic [`REG_ADDR_WIDTH-1:0] regAddrT;

   // Opcodes that the core decodes
   typedef enum logic [`OPCODE_WIDTH-1:0] {
      OP_SPECIAL = 6'h00,
      OP_J       = 6'h02,
      OP_BEQ     = 6'h04,
      OP_BNE     = 6'h05,
      OP_ADDIU   = 6'h09,
      OP_SLTI    = 6'h0a,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_XORI    = 6'h0e,
      OP_LUI     = 6'h0f,
      OP_LW      = 6'h23,
      OP_SW      = 6'h2b
   } opcodeT;

   // R-type function codes
   typedef enum logic [`FUNCT_WIDTH-1:0] {
      FN_SLL  = 6'h00,
      FN_SRL  = 6'h02,
      FN_SRA  = 6'h03,
      FN_ADDU = 6'h21,
      FN_SUBU = 6'h23,
      FN_AND  = 6'h24,
      FN_OR   = 6'h25,
      FN_XOR  = 6'h26,
      FN_NOR  = 6'h27,
      FN_SLT  = 6'h2a,
      FN_SLTU = 6'h2b
   } functT;

   // ALU_ADD is zero so an empty bundle adds
   typedef enum logic [3:0] {
      ALU_ADD  = 4'd0,
      ALU_SUB  = 4'd1,
      ALU_AND  = 4'd2,
      ALU_OR   = 4'd3,
      ALU_XOR  = 4'd4,
      ALU_NOR  = 4'd5,
      ALU_SLT  = 4'd6,
      ALU_SLTU = 4'd7,
      ALU_SLL  = 4'd8,
      ALU_SRL  = 4'd9,
      ALU_SRA  = 4'd10,
      ALU_LUI  = 4'd11
   } aluOpT;

   typedef struct packed {
      logic  regWrite;
      logic  memRead;
      logic  memWrite;
      logic  aluSrcImm;
      logic  useShamt;
      logic  zeroExt;
      logic  regDst;
      logic  branchEq;
      logic  branchNe;
      logic  jump;
      aluOpT aluOp;
   } ctrlT;

endpackage

// File: src/stageLinks.sv
`timescale 1ns/100ps
`include "mipsConsts.svh"

// Decode stage to execute stage register contents
interface decodeExecLink;
   import mipsPkg::*;

   logic                     valid;
   ctrlT                     ctrl;
   regAddrT                  rs;
   regAddrT                  rt;
   regAddrT                  destReg;
   wordT                     rsValue;
   wordT                     rtValue;
   wordT                     immExt;
   logic [`SHAMT_WIDTH-1:0]  shamt;
   // Address of the instruction itself
   wordT                     pc;
   logic [`TARGET_WIDTH-1:0] target;

   modport fetch (
      output valid, ctrl, rs, rt, destReg, rsValue, rtValue, immExt, shamt, pc, target
   );
   modport execute (
      input valid, ctrl, rs, rt, destReg, rsValue, rtValue, immExt, shamt, pc, target
   );
endinterface

// Execute stage to memory/writeback stage register contents
interface execMemLink;
   import mipsPkg::*;

   logic    valid;
   logic    regWrite;
   logic    memRead;
   regAddrT destReg;
   wordT    aluResult;

   modport execute (output valid, regWrite, memRead, destReg, aluResult);
   modport memory (input valid, regWrite, memRead, destReg, aluResult);
endinterface

// File: src/instrDecode.sv
`timescale 1ns/100ps

module instrDecode (
   input  mipsPkg::opcodeT opcode,
   input  mipsPkg::functT  funct,
   output mipsPkg::ctrlT   ctrl
);
   import mipsPkg::*;

   always_comb begin
      ctrl = '0;
      case (opcode)
         OP_SPECIAL: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst = 1'b1;
            case (funct)
               FN_ADDU: ctrl.aluOp = ALU_ADD;
               FN_SUBU: ctrl.aluOp = ALU_SUB;
               FN_AND:  ctrl.aluOp = ALU_AND;
               FN_OR:   ctrl.aluOp = ALU_OR;
               FN_XOR:  ctrl.aluOp = ALU_XOR;
               FN_NOR:  ctrl.aluOp = ALU_NOR;
               FN_SLT:  ctrl.aluOp = ALU_SLT;
               FN_SLTU: ctrl.aluOp = ALU_SLTU;
               // Shifts take the amount from the shamt field
               FN_SLL: begin
                  ctrl.aluOp = ALU_SLL;
                  ctrl.useShamt = 1'b1;
               end
               FN_SRL: begin
                  ctrl.aluOp = ALU_SRL;
                  ctrl.useShamt = 1'b1;
               end
               FN_SRA: begin
                  ctrl.aluOp = ALU_SRA;
                  ctrl.useShamt = 1'b1;
               end
               default: ctrl = '0;
            endcase
         end
         OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluSrcImm = 1'b1;
            // Logical immediates are zero extended
            ctrl.zeroExt = (opcode == OP_ANDI) || (opcode == OP_ORI) ||
                           (opcode == OP_XORI) || (opcode == OP_LUI);
            case (opcode)
               OP_SLTI: ctrl.aluOp = ALU_SLT;
               OP_ANDI: ctrl.aluOp = ALU_AND;
               OP_ORI:  ctrl.aluOp = ALU_OR;
               OP_XORI: ctrl.aluOp = ALU_XOR;
               OP_LUI:  ctrl.aluOp = ALU_LUI;
               default: ctrl.aluOp = ALU_ADD;
            endcase
         end
         OP_LW: begin
            ctrl.regWrite = 1'b1;
            ctrl.memRead = 1'b1;
            ctrl.aluSrcImm = 1'b1;
         end
         OP_SW: begin
            ctrl.memWrite = 1'b1;
            ctrl.aluSrcImm = 1'b1;
         end
         OP_BEQ: ctrl.branchEq = 1'b1;
         OP_BNE: ctrl.branchNe = 1'b1;
         OP_J:   ctrl.jump = 1'b1;
         default: ctrl = '0;
      endcase
   end

endmodule

// File: src/regFile.sv
`timescale 1ns/100ps

module regFile (
   input  logic             clk,
   input  logic             reset,
   input  mipsPkg::regAddrT readAddrA,
   input  mipsPkg::regAddrT readAddrB,
   output mipsPkg::wordT    readDataA,
   output mipsPkg::wordT    readDataB,
   input  logic             wbWrite,
   input  mipsPkg::regAddrT wbAddr,
   input  mipsPkg::wordT    wbData
);
   import mipsPkg::*;

   // r0 has no storage
   wordT regs [1:31];

   always_ff @(posedge clk) begin
      if (wbWrite && wbAddr != '0) begin
         regs[wbAddr] <= wbData;
      end
   end

   // Same-cycle write passes straight through to the reader
   always_comb begin
      if (readAddrA == '0) begin
         readDataA = '0;
      end else if (wbWrite && wbAddr == readAddrA) begin
         readDataA = wbData;
      end else begin
         readDataA = regs[readAddrA];
      end
      if (readAddrB == '0) begin
         readDataB = '0;
      end else if (wbWrite && wbAddr == readAddrB) begin
         readDataB = wbData;
      end else begin
         readDataB = regs[readAddrB];
      end
   end

   wbAddrKnown: assert property (@(posedge clk) disable iff (reset)
      wbWrite |-> !$isunknown(wbAddr));

endmodule

// File: src/fetchDecode.sv
`timescale 1ns/100ps
`include "mipsConsts.svh"

module fetchDecode (
   input  logic             clk,
   input  logic             reset,
   output mipsPkg::wordT    imemAddr,
   input  mipsPkg::wordT    imemData,
   input  logic             redirect,
   input  mipsPkg::wordT    redirectPc,
   input  logic             wbWrite,
   input  mipsPkg::regAddrT wbAddr,
   input  mipsPkg::wordT    wbData,
   decodeExecLink.fetch     link
);
   import mipsPkg::*;

   wordT                     pc;
   wordT                     nextPc;
   logic                     fetchValid;
   opcodeT                   opcode;
   functT                    funct;
   ctrlT                     ctrl;
   regAddrT                  rs;
   regAddrT                  rt;
   regAddrT                  rd;
   logic [`SHAMT_WIDTH-1:0]  shamt;
   logic [`IMM_WIDTH-1:0]    imm;
   logic [`TARGET_WIDTH-1:0] target;
   wordT                     immExt;
   wordT                     rsValue;
   wordT                     rtValue;

   // Hold the reset PC until the first fetch has been issued
   always_comb begin
      if (redirect) begin
         nextPc = redirectPc;
      end else if (fetchValid) begin
         nextPc = pc + wordT'(4);
      end else begin
         nextPc = pc;
      end
   end

   assign imemAddr = nextPc;

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= `RESET_PC;
         fetchValid <= 1'b0;
      end else begin
         pc <= nextPc;
         fetchValid <= 1'b1;
      end
   end

   // Instruction fields
   assign opcode = opcodeT'(imemData[`OP_LSB +: `OPCODE_WIDTH]);
   assign funct  = functT'(imemData[`FUNCT_LSB +: `FUNCT_WIDTH]);
   assign rs     = imemData[`RS_LSB +: `REG_ADDR_WIDTH];
   assign rt     = imemData[`RT_LSB +: `REG_ADDR_WIDTH];
   assign rd     = imemData[`RD_LSB +: `REG_ADDR_WIDTH];
   assign shamt  = imemData[`SHAMT_LSB +: `SHAMT_WIDTH];
   assign imm    = imemData[`IMM_WIDTH-1:0];
   assign target = imemData[`TARGET_WIDTH-1:0];

   assign immExt = ctrl.zeroExt ? {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, imm}
                                : {{(`DATA_WIDTH-`IMM_WIDTH){imm[`IMM_WIDTH-1]}}, imm};

   instrDecode decoder (.opcode(opcode), .funct(funct), .ctrl(ctrl));

   regFile registers (
      .clk(clk),
      .reset(reset),
      .readAddrA(rs),
      .readAddrB(rt),
      .readDataA(rsValue),
      .readDataB(rtValue),
      .wbWrite(wbWrite),
      .wbAddr(wbAddr),
      .wbData(wbData)
   );

   always_ff @(posedge clk) begin
      if (reset) begin
         link.valid <= 1'b0;
         link.ctrl <= '0;
      end else begin
         link.valid <= fetchValid;
         link.ctrl <= ctrl;
      end
   end

   always_ff @(posedge clk) begin
      link.rs <= rs;
      link.rt <= rt;
      link.destReg <= ctrl.regDst ? rd : rt;
      link.rsValue <= rsValue;
      link.rtValue <= rtValue;
      link.immExt <= immExt;
      link.shamt <= shamt;
      link.pc <= pc;
      link.target <= target;
   end

   // Redirect targets from execute must stay on word boundaries
   fetchAligned: assert property (@(posedge clk) disable iff (reset)
      imemAddr[1:0] == 2'b00);

endmodule

// File: src/execute.sv
`timescale 1ns/100ps
`include "mipsConsts.svh"

module execute (
   input  logic             clk,
   input  logic             reset,
   decodeExecLink.execute   link,
   input  logic             wbWrite,
   input  mipsPkg::regAddrT wbAddr,
   input  mipsPkg::wordT    wbData,
   output logic             redirect,
   output mipsPkg::wordT    redirectPc,
   output mipsPkg::wordT    dmemAddr,
   output logic             dmemWe,
   output mipsPkg::wordT    dmemWdata,
   execMemLink.execute      toMem
);
   import mipsPkg::*;

   wordT rsFwd;
   wordT rtFwd;
   wordT aluA;
   wordT aluB;
   wordT aluResult;
   wordT pcPlus4;
   wordT branchTarget;
   wordT jumpTarget;
   logic operandsEqual;
   logic taken;

   // Result leaving M this cycle overrides the stale register value
   assign rsFwd = (wbWrite && wbAddr == link.rs && link.rs != '0) ? wbData : link.rsValue;
   assign rtFwd = (wbWrite && wbAddr == link.rt && link.rt != '0) ? wbData : link.rtValue;

   assign aluA = link.ctrl.useShamt ? {{(`DATA_WIDTH-`SHAMT_WIDTH){1'b0}}, link.shamt} : rsFwd;
   assign aluB = link.ctrl.aluSrcImm ? link.immExt : rtFwd;

   always_comb begin
      case (link.ctrl.aluOp)
         ALU_ADD:  aluResult = aluA + aluB;
         ALU_SUB:  aluResult = aluA - aluB;
         ALU_AND:  aluResult = aluA & aluB;
         ALU_OR:   aluResult = aluA | aluB;
         ALU_XOR:  aluResult = aluA ^ aluB;
         ALU_NOR:  aluResult = ~(aluA | aluB);
         ALU_SLT:  aluResult = wordT'($signed(aluA) < $signed(aluB));
         ALU_SLTU: aluResult = wordT'(aluA < aluB);
         // Shifts move operand B by the amount in A
         ALU_SLL:  aluResult = aluB << aluA[`SHAMT_WIDTH-1:0];
         ALU_SRL:  aluResult = aluB >> aluA[`SHAMT_WIDTH-1:0];
         ALU_SRA:  aluResult = $signed(aluB) >>> aluA[`SHAMT_WIDTH-1:0];
         ALU_LUI:  aluResult = aluB << `IMM_WIDTH;
         default:  aluResult = '0;
      endcase
   end

   // Branch and jump resolution
   assign pcPlus4 = link.pc + wordT'(4);
   assign branchTarget = pcPlus4 + {link.immExt[`DATA_WIDTH-3:0], 2'b00};
   assign jumpTarget = {pcPlus4[`DATA_WIDTH-1:`TARGET_WIDTH+2], link.target, 2'b00};
   assign operandsEqual = (rsFwd == rtFwd);
   assign taken = (link.ctrl.branchEq && operandsEqual) ||
                  (link.ctrl.branchNe && !operandsEqual) || link.ctrl.jump;

   assign redirect = link.valid && taken;
   assign redirectPc = link.ctrl.jump ? jumpTarget : branchTarget;

   // Data memory request with load data returning in M
   assign dmemAddr = aluResult;
   assign dmemWdata = rtFwd;
   assign dmemWe = link.valid && link.ctrl.memWrite;

   always_ff @(posedge clk) begin
      if (reset) begin
         toMem.valid <= 1'b0;
         toMem.regWrite <= 1'b0;
         toMem.memRead <= 1'b0;
      end else begin
         toMem.valid <= link.valid;
         toMem.regWrite <= link.ctrl.regWrite;
         toMem.memRead <= link.ctrl.memRead;
      end
   end

   always_ff @(posedge clk) begin
      toMem.destReg <= link.destReg;
      toMem.aluResult <= aluResult;
   end

   noLoadStore: assert property (@(posedge clk) disable iff (reset)
      link.valid |-> !(link.ctrl.memRead && link.ctrl.memWrite));

endmodule

// File: src/memWriteback.sv
`timescale 1ns/100ps

module memWriteback (
   input  logic              clk,
   input  logic              reset,
   execMemLink.memory        fromExec,
   input  mipsPkg::wordT     dmemRdata,
   output logic              wbWrite,
   output mipsPkg::regAddrT  wbAddr,
   output mipsPkg::wordT     wbData
);
   import mipsPkg::*;

   // Only a valid instruction may write back
   assign wbWrite = fromExec.valid && fromExec.regWrite;
   assign wbAddr = fromExec.destReg;

   // Load data arrives one cycle after the address left E
   always_comb begin
      if (fromExec.memRead) begin
         wbData = dmemRdata;
      end else begin
         wbData = fromExec.aluResult;
      end
   end

   // Nothing retires in reset or the cycle right after it
   quietAfterReset: assert property (@(posedge clk) reset |=> !wbWrite);

endmodule

// File: src/mipsCore.sv
`timescale 1ns/100ps

module mipsCore (
   input  logic          clk,
   input  logic          reset,
   output mipsPkg::wordT imemAddr,
   input  mipsPkg::wordT imemData,
   output mipsPkg::wordT dmemAddr,
   output logic          dmemWe,
   output mipsPkg::wordT dmemWdata,
   input  mipsPkg::wordT dmemRdata
);
   import mipsPkg::*;

   logic    redirect;
   wordT    redirectPc;
   logic    wbWrite;
   regAddrT wbAddr;
   wordT    wbData;

   decodeExecLink deLink ();
   execMemLink    emLink ();

   fetchDecode fetchStage (
      .clk(clk),
      .reset(reset),
      .imemAddr(imemAddr),
      .imemData(imemData),
      .redirect(redirect),
      .redirectPc(redirectPc),
      .wbWrite(wbWrite),
      .wbAddr(wbAddr),
      .wbData(wbData),
      .link(deLink.fetch)
   );

   execute execStage (
      .clk(clk),
      .reset(reset),
      .link(deLink.execute),
      .wbWrite(wbWrite),
      .wbAddr(wbAddr),
      .wbData(wbData),
      .redirect(redirect),
      .redirectPc(redirectPc),
      .dmemAddr(dmemAddr),
      .dmemWe(dmemWe),
      .dmemWdata(dmemWdata),
      .toMem(emLink.execute)
   );

   memWriteback memStage (
      .clk(clk),
      .reset(reset),
      .fromExec(emLink.memory),
      .dmemRdata(dmemRdata),
      .wbWrite(wbWrite),
      .wbAddr(wbAddr),
      .wbData(wbData)
   );

endmodule

// File: sim/mipsCoreTb.sv
`timescale 1ns/100ps

module mipsCoreTb;
   import mipsPkg::*;

   // Store addresses outside the range used by the ordinary stores
   localparam wordT doneAddr = 32'h0000_03f0;
   localparam wordT poisonAddr = 32'h0000_03f4;

   logic   clk = 1'b0;
   logic   reset = 1'b1;
   wordT   imemAddr;
   wordT   imemData = '0;
   wordT   dmemAddr;
   logic   dmemWe;
   wordT   dmemWdata;
   wordT   dmemRdata = '0;

   wordT   instrRom [0:255];
   wordT   dataRam [0:255];
   wordT   fetchAddrHeld = '0;
   wordT   loadAddrHeld = '0;

   // Expected stores in program order
   wordT   expAddrQ [$];
   wordT   expDataQ [$];
   string  expNameQ [$];
   int     expCount = 0;
   int     storeIdx = 0;
   wordT   headAddr = '0;
   wordT   headData = '0;
   string  headName = "none";

   int     progLen = 0;
   int     nextStoreAddr = 0;
   int     timeoutLimit = 1000;
   int     cycle = 0;
   int     outOfReset = 0;
   logic   doneSeen = 1'b0;
   integer seed = 75;

   mipsCore DUT (
      .clk(clk),
      .reset(reset),
      .imemAddr(imemAddr),
      .imemData(imemData),
      .dmemAddr(dmemAddr),
      .dmemWe(dmemWe),
      .dmemWdata(dmemWdata),
      .dmemRdata(dmemRdata)
   );

   always #4 clk = ~clk;

   function automatic wordT rType(functT fn, int rs, int rt, int rd, int sh);
      return {OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
   endfunction

   function automatic wordT iType(opcodeT op, int rs, int rt, logic [15:0] imm);
      return {op, 5'(rs), 5'(rt), imm};
   endfunction

   function automatic wordT jType(int targetIdx);
      return {OP_J, 26'(targetIdx)};
   endfunction

   task automatic emit(wordT instr);
      instrRom[progLen] = instr;
      progLen++;
   endtask

   task automatic loadConst(int rd, wordT value);
      emit(iType(OP_LUI, 0, rd, value[31:16]));
      emit(iType(OP_ORI, rd, rd, value[15:0]));
   endtask

   // Store a register to the next free word and queue what must arrive
   task automatic storeExpected(string name, int rt, wordT value);
      emit(iType(OP_SW, 0, rt, 16'(nextStoreAddr)));
      expAddrQ.push_back(wordT'(nextStoreAddr));
      expDataQ.push_back(value);
      expNameQ.push_back(name);
      nextStoreAddr += 4;
   endtask

   // With a gap the store reads the result through the register file write-through
   task automatic runAluCase(string name, wordT instr, int rd, wordT expected, bit gap);
      emit(instr);
      if (gap) begin
         emit('0);
      end
      storeExpected(name, rd, expected);
   endtask

   initial begin : buildProgram
      wordT        a;
      wordT        b;
      wordT        v;
      wordT        immS;
      logic [15:0] imm;
      logic [4:0]  sh;
      int          i;
      for (i = 0; i < 256; i++) begin
         instrRom[i] = '0;
         dataRam[i] = 32'hd00d_0000 + (wordT'(i) << 2);
      end
      a = $random(seed);
      b = $random(seed);
      v = $random(seed);
      imm = 16'($random(seed));
      sh = 5'($random(seed));
      immS = {{16{imm[15]}}, imm};

      // Opens with a store so a valid leaking out of reset shows on dmemWe
      storeExpected("firstStore", 0, '0);
      loadConst(1, a);
      loadConst(2, b);

      // R-type results are stored by the very next instruction
      runAluCase("addu", rType(FN_ADDU, 1, 2, 3, 0), 3, a + b, 1'b0);
      runAluCase("subu", rType(FN_SUBU, 1, 2, 3, 0), 3, a - b, 1'b0);
      runAluCase("and", rType(FN_AND, 1, 2, 3, 0), 3, a & b, 1'b0);
      runAluCase("or", rType(FN_OR, 1, 2, 3, 0), 3, a | b, 1'b0);
      runAluCase("xor", rType(FN_XOR, 1, 2, 3, 0), 3, a ^ b, 1'b0);
      runAluCase("nor", rType(FN_NOR, 1, 2, 3, 0), 3, ~(a | b), 1'b0);
      runAluCase("slt", rType(FN_SLT, 1, 2, 3, 0), 3, {31'b0, $signed(a) < $signed(b)}, 1'b0);
      runAluCase("sltu", rType(FN_SLTU, 1, 2, 3, 0), 3, {31'b0, a < b}, 1'b0);
      runAluCase("sll", rType(FN_SLL, 0, 2, 3, sh), 3, b << sh, 1'b0);
      runAluCase("srl", rType(FN_SRL, 0, 2, 3, sh), 3, b >> sh, 1'b0);
      runAluCase("sra", rType(FN_SRA, 0, 2, 3, sh), 3, wordT'($signed(b) >>> sh), 1'b0);

      runAluCase("addiu", iType(OP_ADDIU, 1, 4, imm), 4, a + immS, 1'b1);
      runAluCase("slti", iType(OP_SLTI, 1, 4, imm), 4, {31'b0, $signed(a) < $signed(immS)}, 1'b1);
      runAluCase("andi", iType(OP_ANDI, 1, 4, imm), 4, a & {16'h0, imm}, 1'b1);
      runAluCase("ori", iType(OP_ORI, 1, 4, imm), 4, a | {16'h0, imm}, 1'b1);
      runAluCase("xori", iType(OP_XORI, 1, 4, imm), 4, a ^ {16'h0, imm}, 1'b1);
      runAluCase("lui", iType(OP_LUI, 0, 4, imm), 4, {imm, 16'h0}, 1'b1);

      // Load round trip with the loaded value used right away
      loadConst(5, v);
      storeExpected("storeForLoad", 5, v);
      emit(iType(OP_LW, 0, 6, 16'(nextStoreAddr - 4)));
      emit(iType(OP_ADDIU, 6, 7, 16'h0123));
      storeExpected("loadUse", 7, v + 32'h0000_0123);

      // Taken beq skips one store and not-taken bne falls through
      loadConst(8, v ^ a);
      emit(rType(FN_ADDU, 8, 0, 9, 0));
      emit(iType(OP_BEQ, 8, 9, 16'd2));
      storeExpected("beqDelaySlot", 8, v ^ a);
      emit(iType(OP_SW, 0, 8, 16'(poisonAddr)));
      emit(iType(OP_BNE, 8, 9, 16'd2));
      storeExpected("bneDelaySlot", 9, v ^ a);
      storeExpected("bneFallThrough", 8, v ^ a);

      // Jump over a poison store
      emit(jType(progLen + 3));
      storeExpected("jumpDelaySlot", 1, a);
      emit(iType(OP_SW, 0, 1, 16'(poisonAddr)));
      storeExpected("jumpTarget", 2, b);

      emit(iType(OP_SW, 0, 0, 16'(doneAddr)));
      expCount = expAddrQ.size();
      timeoutLimit = 2 * progLen + 50;
   end

   initial begin : releaseReset
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

   // Both memories take the address on the rising edge
   always @(posedge clk) begin
      fetchAddrHeld <= imemAddr;
      loadAddrHeld <= dmemAddr;
      if (!reset && dmemWe) begin
         dataRam[dmemAddr[9:2]] <= dmemWdata;
         if (dmemAddr == doneAddr) begin
            doneSeen <= 1'b1;
         end else begin
            storeIdx <= storeIdx + 1;
         end
      end
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (reset) begin
         outOfReset <= 0;
      end else if (outOfReset < 2) begin
         outOfReset <= outOfReset + 1;
      end
   end

   always @(posedge clk) begin
      if (cycle >= timeoutLimit) begin
         $display("Timeout after %0d cycles, %0d of %0d stores seen", cycle, storeIdx, expCount);
         $display("** FAIL **");
         $fatal(1, "timeout");
      end
   end

   // Read data and the next expected store change on the falling edge
   always @(negedge clk) begin
      imemData <= instrRom[fetchAddrHeld[9:2]];
      dmemRdata <= dataRam[loadAddrHeld[9:2]];
      if (storeIdx < expCount) begin
         headAddr = expAddrQ[storeIdx];
         headData = expDataQ[storeIdx];
         headName = expNameQ[storeIdx];
      end
      if (doneSeen) begin
         if (storeIdx == expCount) begin
            $display("** PASS **");
            $finish;
         end else begin
            $display("MISMATCH completion: expected %0d stores, actual %0d", expCount, storeIdx);
            $display("** FAIL **");
            $fatal(1, "incomplete run");
         end
      end
   end

   resetQuiet: assert property (@(posedge clk) (cycle > 0 && outOfReset < 2) |-> !dmemWe)
      else begin
         $display("Store strobe was high in reset or in the first cycle after it");
         $display("** FAIL **");
         $fatal(1, "store in reset");
      end

   storeMatches: assert property (@(posedge clk) disable iff (reset)
      (dmemWe && dmemAddr != doneAddr && storeIdx < expCount) |->
         (dmemAddr == headAddr && dmemWdata == headData))
      else begin
         $display("MISMATCH %s: expected addr %h data %h, actual addr %h data %h", headName,
            headAddr, headData, $sampled(dmemAddr), $sampled(dmemWdata));
         $display("** FAIL **");
         $fatal(1, "store mismatch");
      end

   extraStore: assert property (@(posedge clk) disable iff (reset)
      (dmemWe && dmemAddr != doneAddr) |-> storeIdx < expCount)
      else begin
         $display("Unexpected store to %h after the last expected one", $sampled(dmemAddr));
         $display("** FAIL **");
         $fatal(1, "extra store");
      end

   neverPoison: assert property (@(posedge clk) disable iff (reset)
      !(dmemWe && dmemAddr == poisonAddr))
      else begin
         $display("A skipped instruction stored to the poison address");
         $display("** FAIL **");
         $fatal(1, "poison store");
      end

   doneInOrder: assert property (@(posedge clk) disable iff (reset)
      (dmemWe && dmemAddr == doneAddr) |-> storeIdx == expCount)
      else begin
         $display("MISMATCH done: expected %0d stores first, actual %0d", expCount, storeIdx);
         $display("** FAIL **");
         $fatal(1, "early done");
      end

endmodule

// File: vlog.f
+incdir+src
src/mipsPkg.sv
src/stageLinks.sv
src/instrDecode.sv
src/regFile.sv
src/fetchDecode.sv
src/execute.sv
src/memWriteback.sv
src/mipsCore.sv
sim/mipsCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run with Verilator, then decide from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -f vlog.f --top-module mipsCoreTb -o mipsCoreSim \
   && ./obj_dir/mipsCoreSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qxF '** PASS **' sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
